//--- common/axis_params.svh
// Default stream geometry only; tdata width must be a multiple of 8 so tkeep covers whole bytes

`ifndef AXIS_PARAMS_SVH
`define AXIS_PARAMS_SVH

// Stream payload width in bits
`define AXIS_DATA_BITS 32

// One keep bit per data byte
`define AXIS_KEEP_BITS (`AXIS_DATA_BITS / 8)

// Slices in the default chain, each adds one cycle of latency
`define AXIS_N_STAGES 2

`endif

//--- common/axis_pkg.sv
// Beat and slice types shared by the stream slices; tid, tdest and tuser are not carried

`include "axis_params.svh"

package axis_pkg;

  // One stream beat as it travels between slices
  typedef struct packed {
    logic [`AXIS_DATA_BITS-1:0] tdata;  // Payload
    logic [`AXIS_KEEP_BITS-1:0] tkeep;  // Byte qualifiers
    logic                       tlast;  // End of packet marker
  } axis_beat_t;

  // Number of beats held inside one skid slice
  typedef enum logic [1:0] {
    SLICE_EMPTY = 2'd0,  // Nothing held, output idle
    SLICE_ONE   = 2'd1,  // Output register full, skid free
    SLICE_TWO   = 2'd2   // Both registers full, upstream stalled
  } slice_state_e;

endpackage

//--- axis_reg/axis_reg.sv
// Two-entry skid slice with registered s_tready; one beat per clock and one cycle latency

module axis_reg (
  input  logic                 aclk,
  input  logic                 rst,
  input  logic                 s_tvalid,
  output logic                 s_tready,
  input  axis_pkg::axis_beat_t s_tdata,
  output logic                 m_tvalid,
  input  logic                 m_tready,
  output axis_pkg::axis_beat_t m_tdata
);

  axis_pkg::slice_state_e state;       // Beats currently held
  axis_pkg::slice_state_e state_next;
  axis_pkg::axis_beat_t   out_beat;    // Beat shown on the master side
  axis_pkg::axis_beat_t   skid_beat;   // Beat caught while the output stalls
  logic                   out_valid;   // Registered m_tvalid
  logic                   in_ready;    // Registered s_tready
  logic                   accept;      // Transfer on the slave side
  logic                   drain;       // Transfer on the master side
  logic                   load_out_in;   // Input goes straight to output
  logic                   load_out_skid; // Skid refills the output
  logic                   load_skid;     // Input parks in skid

  assign accept = s_tvalid && in_ready;
  assign drain  = out_valid && m_tready;

  // Occupancy FSM and datapath steering
  always_comb begin
    state_next    = state;
    load_out_in   = 1'b0;
    load_out_skid = 1'b0;
    load_skid     = 1'b0;
    case (state)
      axis_pkg::SLICE_EMPTY: begin
        if (accept) begin
          state_next  = axis_pkg::SLICE_ONE;  // Bypass skid when empty
          load_out_in = 1'b1;
        end
      end
      axis_pkg::SLICE_ONE: begin
        if (accept && drain) begin
          load_out_in = 1'b1;                 // Streaming case, count unchanged
        end else if (accept) begin
          state_next = axis_pkg::SLICE_TWO;   // Output stalled, catch in skid
          load_skid  = 1'b1;
        end else if (drain) begin
          state_next = axis_pkg::SLICE_EMPTY;
        end
      end
      axis_pkg::SLICE_TWO: begin
        // Upstream is held off here, so only a drain can happen
        if (drain) begin
          state_next    = axis_pkg::SLICE_ONE;
          load_out_skid = 1'b1;               // Skid moves up to output
        end
      end
      default: begin
        state_next = axis_pkg::SLICE_EMPTY;   // Unused encoding recovers to idle
      end
    endcase
  end

  // Control registers; handshake outputs come straight from flops
  always_ff @(posedge aclk) begin
    if (rst) begin
      state     <= axis_pkg::SLICE_EMPTY;
      out_valid <= 1'b0;
      in_ready  <= 1'b1;
    end else begin
      state     <= state_next;
      out_valid <= (state_next != axis_pkg::SLICE_EMPTY);  // Anything held is shown
      in_ready  <= (state_next != axis_pkg::SLICE_TWO);    // Room for one more beat
    end
  end

  // Payload registers
  always_ff @(posedge aclk) begin
    if (load_out_in) begin
      out_beat <= s_tdata;
    end else if (load_out_skid) begin
      out_beat <= skid_beat;
    end
    if (load_skid) begin
      skid_beat <= s_tdata;
    end
  end

  assign s_tready = in_ready;
  assign m_tvalid = out_valid;
  assign m_tdata  = out_beat;

  // A stalled beat must not change under the consumer
  a_hold_data : assert property (
    @(posedge aclk) disable iff (rst)
    (m_tvalid && !m_tready) |=> $stable(m_tdata)
  ) else $error("axis_reg: m_tdata changed while stalled");

  // Valid only drops after the beat was taken
  a_hold_valid : assert property (
    @(posedge aclk) disable iff (rst)
    (m_tvalid && !m_tready) |=> m_tvalid
  ) else $error("axis_reg: m_tvalid fell without a transfer");

  // Full slice never takes a third beat
  a_no_overfill : assert property (
    @(posedge aclk) disable iff (rst)
    (state == axis_pkg::SLICE_TWO) |-> !(s_tvalid && s_tready)
  ) else $error("axis_reg: beat accepted while holding two");

endmodule

//--- axis_reg/axis_reg_array.sv
// Chain of N_STAGES skid slices; latency N_STAGES cycles, capacity 2*N_STAGES beats, N_STAGES >= 1

`include "axis_params.svh"

module axis_reg_array #(
  parameter int N_STAGES = `AXIS_N_STAGES
) (
  input  logic                 aclk,
  input  logic                 rst,
  input  logic                 s_tvalid,
  output logic                 s_tready,
  input  axis_pkg::axis_beat_t s_tdata,
  output logic                 m_tvalid,
  input  logic                 m_tready,
  output axis_pkg::axis_beat_t m_tdata
);

  localparam int OCC_BITS = $clog2(2 * N_STAGES + 1);  // Enough for a full chain

  logic [N_STAGES:0]                       link_tvalid;  // Link i feeds slice i
  logic [N_STAGES:0]                       link_tready;
  axis_pkg::axis_beat_t [N_STAGES:0]       link_tdata;
  logic                                    in_xfer;      // Beat enters the chain
  logic                                    out_xfer;     // Beat leaves the chain
  logic [OCC_BITS-1:0]                     occupancy;    // Beats inside all slices

  if (N_STAGES < 1) begin : g_bad_stages
    $fatal(1, "axis_reg_array: N_STAGES must be at least 1");
  end

  // Port mapping onto the end links
  assign link_tvalid[0]        = s_tvalid;
  assign link_tdata[0]         = s_tdata;
  assign s_tready              = link_tready[0];
  assign m_tvalid              = link_tvalid[N_STAGES];
  assign m_tdata               = link_tdata[N_STAGES];
  assign link_tready[N_STAGES] = m_tready;

  for (genvar i = 0; i < N_STAGES; i++) begin : g_slice
    axis_reg u_axis_reg (
      .aclk     (aclk),
      .rst      (rst),
      .s_tvalid (link_tvalid[i]),
      .s_tready (link_tready[i]),
      .s_tdata  (link_tdata[i]),
      .m_tvalid (link_tvalid[i+1]),
      .m_tready (link_tready[i+1]),
      .m_tdata  (link_tdata[i+1])
    );
  end

  assign in_xfer  = s_tvalid && s_tready;
  assign out_xfer = m_tvalid && m_tready;

  // Running count of beats held, used only by the checks below
  always_ff @(posedge aclk) begin
    if (rst) begin
      occupancy <= '0;
    end else if (in_xfer && !out_xfer) begin
      occupancy <= occupancy + OCC_BITS'(1);
    end else if (!in_xfer && out_xfer) begin
      occupancy <= occupancy - OCC_BITS'(1);
    end
  end

  // Source keeps its beat pending while the chain refuses it
  a_src_hold : assert property (
    @(posedge aclk) disable iff (rst)
    (s_tvalid && !s_tready) |=> (s_tvalid && $stable(s_tdata))
  ) else $error("axis_reg_array: slave beat dropped before acceptance");

  // Ready only drops once the first slice is really full
  a_ready_low_full : assert property (
    @(posedge aclk) disable iff (rst)
    !s_tready |-> (occupancy >= 2)
  ) else $error("axis_reg_array: s_tready low with room in first slice");

  // An empty chain shows nothing at the master
  a_empty_idle : assert property (
    @(posedge aclk) disable iff (rst)
    (occupancy == '0) |-> !m_tvalid
  ) else $error("axis_reg_array: m_tvalid high with no beat inside");

endmodule

//--- verif/axis_reg_array_checker.sv
// Scoreboard for the slice chain; assumes the testbench drives inputs after the clock edge and starts empty

`include "axis_params.svh"

module axis_reg_array_checker #(
  parameter int N_STAGES = `AXIS_N_STAGES
) (
  input  logic                 aclk,
  input  logic                 rst,
  input  logic                 s_tvalid,
  input  logic                 s_tready,
  input  axis_pkg::axis_beat_t s_tdata,
  input  logic                 m_tvalid,
  input  logic                 m_tready,
  input  axis_pkg::axis_beat_t m_tdata,
  input  logic                 burst,      // Back-to-back window from the source
  output int                   errors,
  output int                   beats_in,
  output int                   beats_out
);

  axis_pkg::axis_beat_t exp_q[$];         // Beats in flight, oldest first
  int                   acc_cyc_q[$];     // Slave accept cycle per beat
  logic                 empty_q[$];       // Chain was empty at accept
  int                   err_count = 0;
  int                   in_count = 0;
  int                   out_count = 0;
  int                   cycle = 0;
  int                   last_low = -1;    // Last cycle with m_tready low
  logic                 rst_prev = 1'b0;
  logic                 stall_prev = 1'b0;
  int                   burst_cyc = 0;    // Edges seen inside the back-to-back run
  logic                 held_valid = 1'b0;
  axis_pkg::axis_beat_t held;

  assign errors    = err_count;
  assign beats_in  = in_count;
  assign beats_out = out_count;

  always @(posedge aclk) begin : watch
    axis_pkg::axis_beat_t exp;
    int                   acc_cyc;
    int                   pre_size;
    logic                 was_empty;
    logic                 in_xfer;
    logic                 out_xfer;
    pre_size = exp_q.size();
    in_xfer  = s_tvalid && s_tready;
    out_xfer = m_tvalid && m_tready;
    cycle++;
    if (rst) begin
      if (rst_prev && m_tvalid) begin
        $display("m_tvalid high during reset at cycle %0d", cycle);
        err_count++;
      end
      rst_prev  = 1'b1;
      burst_cyc = 0;
    end else begin
      if (rst_prev && (!s_tready || m_tvalid)) begin
        $display("Chain not idle on first cycle after reset");
        err_count++;
      end
      rst_prev = 1'b0;
      // Stalled beat must hold
      if (held_valid && !m_tvalid) begin
        $display("m_tvalid fell without a transfer at cycle %0d", cycle);
        err_count++;
      end else if (held_valid && m_tdata !== held) begin
        $display("** Error: m_tdata expected %h actual %h", held, m_tdata);
        err_count++;
      end
      held_valid = m_tvalid && !m_tready;
      held       = m_tdata;
      // Full chain is the only reason to refuse during a stall
      if (stall_prev && !m_tready && (s_tready != (pre_size < 2 * N_STAGES))) begin
        $display("** Error: s_tready expected %h actual %h", pre_size < 2 * N_STAGES, s_tready);
        err_count++;
      end
      stall_prev = !m_tready;
      if (!m_tready) last_low = cycle;
      if (out_xfer) begin
        if (exp_q.size() == 0) begin
          $display("Beat left the chain that never entered, cycle %0d", cycle);
          err_count++;
        end else begin
          exp       = exp_q.pop_front();
          acc_cyc   = acc_cyc_q.pop_front();
          was_empty = empty_q.pop_front();
          if (m_tdata.tdata !== exp.tdata) begin
            $display("** Error: m_tdata.tdata expected %h actual %h", exp.tdata, m_tdata.tdata);
            err_count++;
          end
          if (m_tdata.tkeep !== exp.tkeep) begin
            $display("** Error: m_tdata.tkeep expected %h actual %h", exp.tkeep, m_tdata.tkeep);
            err_count++;
          end
          if (m_tdata.tlast !== exp.tlast) begin
            $display("** Error: m_tdata.tlast expected %h actual %h", exp.tlast, m_tdata.tlast);
            err_count++;
          end
          // Latency only meaningful for an empty, never stalled path
          if (was_empty && last_low < acc_cyc && (cycle - acc_cyc) != N_STAGES) begin
            $display("** Error: latency expected %h actual %h", N_STAGES, cycle - acc_cyc);
            err_count++;
          end
          $display("entry %0d done: tdata %h, %0d cycles in chain, %0d errors so far",
                   out_count, m_tdata.tdata, cycle - acc_cyc, err_count);
        end
        out_count++;
      end
      if (in_xfer) begin
        exp_q.push_back(s_tdata);
        acc_cyc_q.push_back(cycle);
        empty_q.push_back(pre_size == 0);
        in_count++;
      end
      // Back-to-back run must move a beat at both ports every cycle
      if (burst) begin
        burst_cyc++;
        if (!in_xfer) begin
          $display("Source beat refused during back-to-back run at cycle %0d", cycle);
          err_count++;
        end
        // First beat of the run reaches the master N_STAGES edges after entering
        if (burst_cyc > N_STAGES && !out_xfer) begin
          $display("Missed transfer at master during back-to-back run at cycle %0d", cycle);
          err_count++;
        end
      end else begin
        burst_cyc = 0;
      end
    end
  end

endmodule

//--- verif/tb_axis_reg_array.sv
// Testbench for the default chain; entries 2 to 5 form the back-to-back run, entries 10 up get random gaps

`include "axis_params.svh"

module tb_axis_reg_array;

  localparam int N_STAGES    = `AXIS_N_STAGES;
  localparam int TAB_LEN     = 14;
  localparam int MAX_GAP     = 7;    // Table gap plus up to 3 random cycles
  localparam int MAX_STALL   = 8;
  localparam int CYCLE_LIMIT = TAB_LEN * (MAX_GAP + MAX_STALL + 2 * N_STAGES + 4) + 100;
  localparam int DRIVE       = 10;   // Input skew after the rising edge

  logic                 aclk;
  logic                 rst;
  logic                 s_tvalid;
  logic                 s_tready;
  axis_pkg::axis_beat_t s_tdata;
  logic                 m_tvalid;
  logic                 m_tready;
  axis_pkg::axis_beat_t m_tdata;
  logic                 burst;
  int                   errors;
  int                   beats_in;
  int                   beats_out;
  int                   seed;
  int                   cycle_count;
  axis_pkg::axis_beat_t tab_beat [TAB_LEN];
  int                   tab_gap [TAB_LEN];
  int                   tab_stall [TAB_LEN];

  axis_reg_array #(.N_STAGES(N_STAGES)) u_axis_reg_array (
    .aclk     (aclk),
    .rst      (rst),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata)
  );

  axis_reg_array_checker #(.N_STAGES(N_STAGES)) u_checker (
    .aclk (aclk), .rst (rst),
    .s_tvalid (s_tvalid), .s_tready (s_tready), .s_tdata (s_tdata),
    .m_tvalid (m_tvalid), .m_tready (m_tready), .m_tdata (m_tdata),
    .burst (burst), .errors (errors), .beats_in (beats_in), .beats_out (beats_out)
  );

  always #50 aclk = ~aclk;

  // Run limit from table length
  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, stream stopped moving", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic set_entry(input int i, input logic [31:0] data, input logic [3:0] keep,
                           input logic last, input int gap, input int stall);
    tab_beat[i].tdata = data;
    tab_beat[i].tkeep = keep;
    tab_beat[i].tlast = last;
    tab_gap[i]        = gap;
    tab_stall[i]      = stall;
  endtask

  task automatic wait_cycle();
    @(posedge aclk);
    #DRIVE;
  endtask

  // Holds the beat until the chain takes it
  task automatic send_beat(input axis_pkg::axis_beat_t beat, input int gap);
    logic taken;
    if (gap > 0) begin
      s_tvalid = 1'b0;
      repeat (gap) wait_cycle();
    end
    s_tvalid = 1'b1;
    s_tdata  = beat;
    taken    = 1'b0;
    while (!taken) begin
      taken = s_tready;  // Flop output, stable since the last edge
      wait_cycle();
    end
  endtask

  task automatic take_beat(input int stall);
    logic taken;
    if (stall > 0) begin
      m_tready = 1'b0;
      repeat (stall) wait_cycle();
    end
    m_tready = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      taken = m_tvalid;
      wait_cycle();
    end
  endtask

  initial begin
    aclk        = 1'b0;
    rst         = 1'b1;
    s_tvalid    = 1'b0;
    s_tdata     = '0;
    m_tready    = 1'b1;
    burst       = 1'b0;
    cycle_count = 0;
    seed        = 32'h3acc;
    set_entry(0,  32'hdead_beef, 4'hf, 1'b0, 3, 0);  // Empty chain, latency
    set_entry(1,  32'h0123_4567, 4'h3, 1'b1, 4, 0);
    set_entry(2,  32'ha5a5_0002, 4'hf, 1'b0, 0, 0);  // Back-to-back run
    set_entry(3,  32'h5a5a_0003, 4'hf, 1'b0, 0, 0);
    set_entry(4,  32'hffff_0004, 4'h1, 1'b0, 0, 0);
    set_entry(5,  32'h0000_0005, 4'hf, 1'b1, 0, 0);
    set_entry(6,  32'h1111_0006, 4'hf, 1'b0, 0, 8);  // Long stall fills the chain
    set_entry(7,  32'h2222_0007, 4'h7, 1'b0, 0, 0);
    set_entry(8,  32'h3333_0008, 4'hf, 1'b0, 0, 0);
    set_entry(9,  32'h4444_0009, 4'he, 1'b1, 0, 0);
    set_entry(10, 32'hc0de_000a, 4'hf, 1'b0, 1, 3);  // Random gaps from here
    set_entry(11, 32'hbead_000b, 4'hf, 1'b0, 0, 0);
    set_entry(12, 32'hf00d_000c, 4'h8, 1'b0, 2, 6);
    set_entry(13, 32'hcafe_000d, 4'hf, 1'b1, 0, 0);
    repeat (4) @(posedge aclk);
    #DRIVE;
    rst = 1'b0;
    wait_cycle();
    fork
      begin : source
        int gap;
        for (int i = 0; i < TAB_LEN; i++) begin
          gap = tab_gap[i];
          if (i >= 10) gap = gap + ($random(seed) & 3);
          if (i == 2) burst = 1'b1;
          send_beat(tab_beat[i], gap);
          if (i == 5) burst = 1'b0;
        end
        s_tvalid = 1'b0;
      end
      begin : sink
        for (int i = 0; i < TAB_LEN; i++) begin
          take_beat(tab_stall[i]);
        end
      end
    join
    repeat (2) wait_cycle();
    $display("Summary: %0d beats in, %0d beats out, %0d errors", beats_in, beats_out, errors);
    if (errors == 0 && beats_in == TAB_LEN && beats_out == beats_in) begin
      $display("All checks passed");
    end else begin
      if (beats_out != beats_in) $display("Beat count mismatch, beats were lost or duplicated");
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- axis_reg_array.f
+incdir+common
common/axis_pkg.sv
axis_reg/axis_reg.sv
axis_reg/axis_reg_array.sv
verif/axis_reg_array_checker.sv
verif/tb_axis_reg_array.sv

//--- run_verilator.sh
#!/bin/sh
# Builds the stream slice chain testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  -f axis_reg_array.f \
  --top-module tb_axis_reg_array \
  -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

if [ ! -x obj_dir/Vtb_axis_reg_array ]; then
  echo "Simulation binary missing after build"
  exit 1
fi

output=$(./obj_dir/Vtb_axis_reg_array 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi
